//--- logic/csrPkg.sv
// Machine-mode CSR layout
// CSR numbers, register field structs, synchronous trap causes and mtvec modes

package csrPkg;

    // Machine-mode CSR addresses in use
    typedef enum logic [11:0] {
        CSR_MSTATUS  = 12'h300,
        CSR_MIE      = 12'h304,
        CSR_MTVEC    = 12'h305,
        CSR_MSCRATCH = 12'h340,
        CSR_MEPC     = 12'h341,
        CSR_MCAUSE   = 12'h342,
        CSR_MTVAL    = 12'h343,
        CSR_MIP      = 12'h344,
        CSR_MCYCLE   = 12'hB00,
        CSR_MINSTRET = 12'hB02
    } csrNumT;

    // Only MIE and MPIE have a meaning here, other bits keep what was written
    typedef struct packed {
        logic [23:0] rsvdHi;
        logic        mpie;    // bit 7
        logic [2:0]  rsvdMid;
        logic        mie;     // bit 3
        logic [2:0]  rsvdLo;
    } mstatusT;

    typedef struct packed {
        logic [23:0] zeroHi;
        logic        mtip;    // machine timer pending
        logic [6:0]  zeroLo;
    } mipT;

    typedef struct packed {
        logic        isInterrupt;
        logic [30:0] code;
    } mcauseT;

    typedef enum logic [1:0] {
        DIRECT   = 2'd0,
        VECTORED = 2'd1
    } mtvecModeT;

    typedef struct packed {
        logic [29:0] base;    // word aligned handler base
        mtvecModeT   mode;
    } mtvecT;

    // Complete state of one hart
    typedef struct packed {
        mstatusT     mstatus;
        logic [31:0] mie;
        mipT         mip;
        mcauseT      mcause;
        mtvecT       mtvec;
        logic [31:0] mtval;
        logic [31:0] mepc;
        logic [31:0] mscratch;
        logic [31:0] mcycle;
        logic [31:0] minstret;
    } csrBodyT;

    // Synchronous exception codes
    typedef enum logic [3:0] {
        CAUSE_INSN_MISALIGNED  = 4'd0,
        CAUSE_ILLEGAL_INSN     = 4'd2,
        CAUSE_BREAKPOINT       = 4'd3,
        CAUSE_LOAD_MISALIGNED  = 4'd4,
        CAUSE_LOAD_FAULT       = 4'd5,
        CAUSE_STORE_MISALIGNED = 4'd6,
        CAUSE_STORE_FAULT      = 4'd7,
        CAUSE_ECALL_M          = 4'd11
    } trapCauseT;

    localparam int unsigned TimerCause = 7;    // machine timer interrupt code

endpackage

//--- logic/clusterPkg.sv
// Command and response transport for the CSR cluster
// Command kinds, CSR operation codes and the commit-side command/response structs

package clusterPkg;

    import csrPkg::*;

    typedef enum logic [1:0] {
        CSR_OP    = 2'd0,
        TRAP      = 2'd1,
        MRET      = 2'd2,
        INTERRUPT = 2'd3
    } cmdKindT;

    typedef enum logic [1:0] {
        READ  = 2'd0,
        WRITE = 2'd1,
        SET   = 2'd2,
        CLEAR = 2'd3
    } csrOpT;

    // One commit-side command, tagged with its hart
    typedef struct packed {
        logic        valid;
        logic [7:0]  hartId;
        cmdKindT     kind;
        csrOpT       op;
        csrNumT      num;
        logic [31:0] wdata;
        trapCauseT   cause;
        logic [31:0] pc;
        logic [31:0] tval;
        logic [1:0]  retired;    // instructions committed with this command
    } csrCmdT;

    typedef struct packed {
        logic        valid;
        logic [7:0]  hartId;
        logic [31:0] rdata;       // CSR value before the command
        logic        redirect;
        logic [31:0] target;
        logic        irqPending;  // timer interrupt would be taken
    } csrRespT;

endpackage

//--- logic/csrCmdRouter.sv
// Command router
// Registers the commit-side command and selects the CSR unit of its hart

`timescale 1ns/1ps

module csrCmdRouter
    import clusterPkg::*;
#(
    parameter int NumHarts = 4
) (
    input  logic                clk,
    input  logic                rstN,
    input  csrCmdT              cmd,
    output csrCmdT              unitCmd,
    output logic [NumHarts-1:0] unitSel
);

    csrCmdT cmdQ;
    logic   validQ;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validQ <= 1'b0;
        end else begin
            validQ <= cmd.valid;
        end
    end

    always_ff @(posedge clk) begin
        cmdQ <= cmd;
    end

    always_comb begin
        unitCmd       = cmdQ;
        unitCmd.valid = validQ;
        for (int h = 0; h < NumHarts; h++) begin
            unitSel[h] = validQ && (cmdQ.hartId == 8'(h));    // one-hot decode
        end
    end

    // Traps for a missing hart would be silently lost
    assert property (@(posedge clk) disable iff (!rstN)
        unitCmd.valid && (unitCmd.kind inside {TRAP, INTERRUPT})
            |-> int'(unitCmd.hartId) < NumHarts)
        else $error("Trap or interrupt sent to nonexistent hart %0d", unitCmd.hartId);

endmodule

//--- logic/csrUnit.sv
// Per-hart machine-mode CSR file
// Serves CSR reads and read-modify-writes, trap, MRET and timer interrupt entry,
// keeps mcycle/minstret and computes the redirect target

`timescale 1ns/1ps

module csrUnit
    import csrPkg::*;
    import clusterPkg::*;
(
    input  logic    clk,
    input  logic    rstN,
    input  logic    sel,
    input  csrCmdT  cmd,
    input  logic    mtip,
    output csrRespT resp
);

    csrBodyT     csrReg;
    csrBodyT     csrNext;
    logic [31:0] rv;    // current value of the addressed CSR
    logic [31:0] wv;    // value after the CSR operation
    logic [31:0] trapTarget;
    logic [31:0] irqTarget;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            csrReg <= '0;
        end else begin
            csrReg <= csrNext;
        end
    end

    // Read side
    always_comb begin
        case (cmd.num)
            CSR_MSTATUS:  rv = csrReg.mstatus;
            CSR_MIE:      rv = csrReg.mie;
            CSR_MIP:      rv = csrReg.mip;
            CSR_MCAUSE:   rv = csrReg.mcause;
            CSR_MTVEC:    rv = csrReg.mtvec;
            CSR_MTVAL:    rv = csrReg.mtval;
            CSR_MEPC:     rv = csrReg.mepc;
            CSR_MSCRATCH: rv = csrReg.mscratch;
            CSR_MCYCLE:   rv = csrReg.mcycle;
            CSR_MINSTRET: rv = csrReg.minstret;
            default:      rv = '0;
        endcase

        case (cmd.op)
            WRITE:   wv = cmd.wdata;
            SET:     wv = rv | cmd.wdata;
            CLEAR:   wv = rv & ~cmd.wdata;
            default: wv = rv;
        endcase

        trapTarget = {csrReg.mtvec.base, 2'b00};
        // Vectored mode jumps to base + 4 * cause
        if (csrReg.mtvec.mode == VECTORED) begin
            irqTarget = {csrReg.mtvec.base + 30'(TimerCause), 2'b00};
        end else begin
            irqTarget = trapTarget;
        end
    end

    // State update
    always_comb begin
        csrNext = csrReg;
        csrNext.mcycle = csrReg.mcycle + 32'd1;    // free running
        if (sel) begin
            csrNext.minstret = csrReg.minstret + 32'(cmd.retired);
        end

        if (sel) begin
            case (cmd.kind)
                CSR_OP: begin
                    if (cmd.op != READ) begin
                        case (cmd.num)
                            CSR_MSTATUS:  csrNext.mstatus  = mstatusT'(wv);
                            CSR_MIE:      csrNext.mie      = wv;
                            CSR_MCAUSE:   csrNext.mcause   = mcauseT'(wv);
                            CSR_MTVEC:    csrNext.mtvec    = mtvecT'(wv);
                            CSR_MTVAL:    csrNext.mtval    = wv;
                            CSR_MEPC:     csrNext.mepc     = wv;
                            CSR_MSCRATCH: csrNext.mscratch = wv;
                            CSR_MCYCLE:   csrNext.mcycle   = wv;    // write beats increment
                            CSR_MINSTRET: csrNext.minstret = wv;
                            default: ;    // mip and unknown numbers ignore writes
                        endcase
                    end
                end
                TRAP: begin
                    csrNext.mstatus.mpie = csrReg.mstatus.mie;
                    csrNext.mstatus.mie  = 1'b0;
                    csrNext.mepc         = cmd.pc;
                    csrNext.mtval        = cmd.tval;
                    csrNext.mcause.isInterrupt = 1'b0;
                    csrNext.mcause.code        = 31'(cmd.cause);
                end
                MRET: begin
                    csrNext.mstatus.mie = csrReg.mstatus.mpie;
                end
                default: begin    // INTERRUPT
                    csrNext.mstatus.mpie = csrReg.mstatus.mie;
                    csrNext.mstatus.mie  = 1'b0;
                    csrNext.mepc         = cmd.pc;
                    csrNext.mtval        = cmd.pc;
                    csrNext.mcause.isInterrupt = 1'b1;
                    csrNext.mcause.code        = 31'(TimerCause);
                end
            endcase
        end

        // mip follows the timer, all other bits stay zero
        csrNext.mip      = '0;
        csrNext.mip.mtip = mtip;
    end

    // Response
    always_comb begin
        resp.valid      = sel;
        resp.hartId     = cmd.hartId;
        resp.rdata      = (cmd.kind == CSR_OP) ? rv : '0;
        resp.redirect   = (cmd.kind != CSR_OP);
        resp.irqPending = csrReg.mstatus.mie & csrReg.mie[7] & csrReg.mip.mtip;
        case (cmd.kind)
            TRAP:      resp.target = trapTarget;
            MRET:      resp.target = csrReg.mepc;
            INTERRUPT: resp.target = irqTarget;
            default:   resp.target = '0;
        endcase
    end

    assert property (@(posedge clk) disable iff (!rstN)
        sel && cmd.kind == TRAP |-> cmd.cause inside {
            CAUSE_INSN_MISALIGNED, CAUSE_ILLEGAL_INSN, CAUSE_BREAKPOINT,
            CAUSE_LOAD_MISALIGNED, CAUSE_LOAD_FAULT, CAUSE_STORE_MISALIGNED,
            CAUSE_STORE_FAULT, CAUSE_ECALL_M})
        else $error("Illegal trap cause %0d", cmd.cause);

    // mip is read-only
    assert property (@(posedge clk) disable iff (!rstN)
        sel && cmd.kind == CSR_OP && cmd.op != READ |-> cmd.num != CSR_MIP)
        else $error("Write to read-only CSR mip");

endmodule

//--- logic/csrRespCollector.sv
// Response collector
// Picks the response of the selected CSR unit and registers it

`timescale 1ns/1ps

module csrRespCollector
    import clusterPkg::*;
#(
    parameter int NumHarts = 4
) (
    input  logic                clk,
    input  logic                rstN,
    input  csrRespT             unitResp [NumHarts],
    input  logic [NumHarts-1:0] unitSel,
    output csrRespT             resp
);

    csrRespT respNext;
    csrRespT respQ;
    logic    validQ;

    always_comb begin
        respNext = '0;
        for (int h = 0; h < NumHarts; h++) begin
            if (unitSel[h]) begin
                respNext = unitResp[h];
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validQ <= 1'b0;
        end else begin
            validQ <= |unitSel;    // no response for a missing hart
        end
    end

    always_ff @(posedge clk) begin
        respQ <= respNext;
    end

    always_comb begin
        resp       = respQ;
        resp.valid = validQ;
    end

    assert property (@(posedge clk) disable iff (!rstN) $onehot0(unitSel))
        else $error("More than one CSR unit selected: %b", unitSel);

endmodule

//--- logic/clintTimer.sv
// CLINT-style machine timer on APB
// Prescaled 64-bit mtime, one mtimecmp per hart, registered timer interrupts

`timescale 1ns/1ps

module clintTimer #(
    parameter int NumHarts = 4,
    parameter int TickDiv  = 4
) (
    input  logic                clk,
    input  logic                rstN,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [11:0]         paddr,
    input  logic [31:0]         pwdata,
    output logic [31:0]         prdata,
    output logic                pready,
    output logic                pslverr,
    output logic [NumHarts-1:0] timerIrq
);

    localparam int PreW = (TickDiv > 1) ? $clog2(TickDiv) : 1;

    logic [PreW-1:0] preCnt;
    logic            tick;
    logic [63:0]     mtime;
    logic [63:0]     mtimecmp [NumHarts];
    logic [8:0]      dwordIdx;    // 8-byte slot of the address
    logic            inMap;
    logic            wrEn;

    assign dwordIdx = paddr[11:3];
    assign inMap = (paddr[1:0] == 2'b00) &&
                   ((dwordIdx == 9'd0) ||
                    (dwordIdx >= 9'd2 && int'(dwordIdx) < NumHarts + 2));
    assign wrEn    = psel && penable && pwrite && inMap;
    assign tick    = (preCnt == PreW'(TickDiv - 1));
    assign pready  = 1'b1;    // zero wait states
    assign pslverr = psel && penable && !inMap;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            preCnt   <= '0;
            mtime    <= '0;
            timerIrq <= '0;
            for (int h = 0; h < NumHarts; h++) begin
                mtimecmp[h] <= '1;
            end
        end else begin
            preCnt <= tick ? '0 : preCnt + 1'b1;
            if (wrEn && dwordIdx == 9'd0) begin
                if (paddr[2]) mtime[63:32] <= pwdata;    // write wins over tick
                else          mtime[31:0]  <= pwdata;
            end else if (tick) begin
                mtime <= mtime + 64'd1;
            end
            for (int h = 0; h < NumHarts; h++) begin
                if (wrEn && dwordIdx == 9'(h + 2)) begin
                    if (paddr[2]) mtimecmp[h][63:32] <= pwdata;
                    else          mtimecmp[h][31:0]  <= pwdata;
                end
                timerIrq[h] <= (mtime >= mtimecmp[h]);
            end
        end
    end

    // Read mux
    always_comb begin
        prdata = '0;
        if (dwordIdx == 9'd0) begin
            prdata = paddr[2] ? mtime[63:32] : mtime[31:0];
        end
        for (int h = 0; h < NumHarts; h++) begin
            if (dwordIdx == 9'(h + 2)) begin
                prdata = paddr[2] ? mtimecmp[h][63:32] : mtimecmp[h][31:0];
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) $rose(penable) |-> psel)
        else $error("APB penable raised without psel");

endmodule

//--- logic/csrCluster.sv
// Machine-mode CSR cluster top
// Command router, one CSR unit per hart, response collector and APB timer

`timescale 1ns/1ps

module csrCluster
    import clusterPkg::*;
#(
    parameter int NumHarts = 4,
    parameter int TickDiv  = 4
) (
    input  logic        clk,
    input  logic        rstN,
    input  csrCmdT      cmd,
    output csrRespT     resp,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [11:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    csrCmdT              unitCmd;
    logic [NumHarts-1:0] unitSel;
    csrRespT             unitResp [NumHarts];
    logic [NumHarts-1:0] timerIrq;

    csrCmdRouter #(.NumHarts(NumHarts)) router (
        .clk(clk), .rstN(rstN), .cmd(cmd),
        .unitCmd(unitCmd), .unitSel(unitSel)
    );

    for (genvar gh = 0; gh < NumHarts; gh++) begin : genHart
        csrUnit unit (
            .clk(clk), .rstN(rstN), .sel(unitSel[gh]), .cmd(unitCmd),
            .mtip(timerIrq[gh]), .resp(unitResp[gh])
        );
    end

    csrRespCollector #(.NumHarts(NumHarts)) collector (
        .clk(clk), .rstN(rstN), .unitResp(unitResp), .unitSel(unitSel), .resp(resp)
    );

    clintTimer #(.NumHarts(NumHarts), .TickDiv(TickDiv)) timer (
        .clk(clk), .rstN(rstN),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .timerIrq(timerIrq)
    );

endmodule

//--- test/csrModel.svh
// Reference model of the CSR cluster
// Keeps every hart's machine-mode CSRs and predicts the response to each command

`ifndef CSR_MODEL_SVH
`define CSR_MODEL_SVH

typedef struct packed {
    csrRespT     resp;
    logic        boundOnly;     // rdata only has a lower bound (mcycle)
    logic        trackCycle;    // plain mcycle read, raises the bound
    logic [31:0] bound;
    logic [31:0] due;           // cycle the response must show up in
} expT;

csrBodyT     modelCsr   [NumHarts];
logic [31:0] cycleBound [NumHarts];
logic        modelMtip  [NumHarts];

function automatic logic [31:0] readModel(int h, csrNumT num);
    case (num)
        CSR_MSTATUS:  return modelCsr[h].mstatus;
        CSR_MIE:      return modelCsr[h].mie;
        CSR_MIP:      return {24'h0, modelMtip[h], 7'h0};
        CSR_MCAUSE:   return modelCsr[h].mcause;
        CSR_MTVEC:    return modelCsr[h].mtvec;
        CSR_MTVAL:    return modelCsr[h].mtval;
        CSR_MEPC:     return modelCsr[h].mepc;
        CSR_MSCRATCH: return modelCsr[h].mscratch;
        CSR_MCYCLE:   return cycleBound[h];
        CSR_MINSTRET: return modelCsr[h].minstret;
        default:      return 32'h0;
    endcase
endfunction

function automatic void writeModel(int h, csrNumT num, logic [31:0] v);
    case (num)
        CSR_MSTATUS:  modelCsr[h].mstatus  = mstatusT'(v);
        CSR_MIE:      modelCsr[h].mie      = v;
        CSR_MCAUSE:   modelCsr[h].mcause   = mcauseT'(v);
        CSR_MTVEC:    modelCsr[h].mtvec    = mtvecT'(v);
        CSR_MTVAL:    modelCsr[h].mtval    = v;
        CSR_MEPC:     modelCsr[h].mepc     = v;
        CSR_MSCRATCH: modelCsr[h].mscratch = v;
        CSR_MCYCLE:   cycleBound[h]        = v;
        CSR_MINSTRET: modelCsr[h].minstret = v;
        default: ;    // mip is read-only
    endcase
endfunction

// Expected response, state of the hart advanced past the command
function automatic expT predict(csrCmdT c);
    expT         e;
    int          h;
    logic [31:0] old;
    logic [31:0] nv;
    logic [31:0] base;
    e = '0;
    h = int'(c.hartId);
    if (h >= NumHarts) return e;    // no such hart, no response
    base = readModel(h, CSR_MTVEC) & 32'hFFFF_FFFC;
    old  = readModel(h, c.num);
    e.resp.valid      = 1'b1;
    e.resp.hartId     = c.hartId;
    e.resp.irqPending = modelCsr[h].mstatus.mie & modelCsr[h].mie[7] & modelMtip[h];
    e.resp.redirect   = (c.kind != CSR_OP);
    modelCsr[h].minstret = modelCsr[h].minstret + 32'(c.retired);
    case (c.kind)
        CSR_OP: begin
            e.resp.rdata = old;
            if (c.num == CSR_MCYCLE) begin
                e.boundOnly  = 1'b1;
                e.bound      = old;
                e.trackCycle = (c.op == READ);
            end
            case (c.op)
                WRITE:   nv = c.wdata;
                SET:     nv = old | c.wdata;
                CLEAR:   nv = old & ~c.wdata;
                default: nv = old;
            endcase
            if (c.op != READ) writeModel(h, c.num, nv);    // write beats minstret count
        end
        TRAP: begin
            e.resp.target = base;
            modelCsr[h].mstatus.mpie = modelCsr[h].mstatus.mie;
            modelCsr[h].mstatus.mie  = 1'b0;
            modelCsr[h].mepc   = c.pc;
            modelCsr[h].mtval  = c.tval;
            modelCsr[h].mcause = mcauseT'({1'b0, 27'd0, c.cause});
        end
        MRET: begin
            e.resp.target = modelCsr[h].mepc;
            modelCsr[h].mstatus.mie = modelCsr[h].mstatus.mpie;
        end
        default: begin
            // Timer interrupt, vectored mode adds 4 * 7
            e.resp.target = (modelCsr[h].mtvec.mode == VECTORED) ? base + 32'd28 : base;
            modelCsr[h].mstatus.mpie = modelCsr[h].mstatus.mie;
            modelCsr[h].mstatus.mie  = 1'b0;
            modelCsr[h].mepc   = c.pc;
            modelCsr[h].mtval  = c.pc;
            modelCsr[h].mcause = mcauseT'(32'h8000_0007);
        end
    endcase
    return e;
endfunction

`endif

//--- test/csrClusterTb.sv
// Testbench for the CSR cluster
// Random CSR, trap, MRET and interrupt commands checked against a reference model,
// plus the CLINT timer over APB and the mcycle/minstret counters

`timescale 1ns/1ps

module csrClusterTb
    import csrPkg::*;
    import clusterPkg::*;
();

    localparam int NumHarts    = 4;
    localparam int TickDiv     = 4;
    localparam int ResetCycles = 16;
    localparam int NumRandOps  = 120;
    localparam int NumTraps    = 12;
    localparam int NumIrqs     = 8;
    localparam int NumRetire   = 12;
    localparam int NumApbOps   = 16;
    localparam int NumTimeRds  = 6;
    localparam int PlannedCycles = ResetCycles + 2 * NumRandOps + 12 * NumTraps
        + 10 * NumIrqs + 3 * NumApbOps + 10 * NumTimeRds + 40 + 2 * NumRetire + 40;
    localparam int LimitCycles = 2 * PlannedCycles;

    logic        clk;
    logic        rstN;
    csrCmdT      cmd;
    csrRespT     resp;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    integer seed = 43543;
    int     cyc  = 0;
    csrNumT rwNums [5] = '{CSR_MSCRATCH, CSR_MTVEC, CSR_MEPC, CSR_MIE, CSR_MSTATUS};
    trapCauseT legalCauses [8] = '{CAUSE_INSN_MISALIGNED, CAUSE_ILLEGAL_INSN,
        CAUSE_BREAKPOINT, CAUSE_LOAD_MISALIGNED, CAUSE_LOAD_FAULT,
        CAUSE_STORE_MISALIGNED, CAUSE_STORE_FAULT, CAUSE_ECALL_M};

    `include "csrModel.svh"

    expT expQ [$];

    csrCluster #(.NumHarts(NumHarts), .TickDiv(TickDiv)) dut (
        .clk(clk), .rstN(rstN), .cmd(cmd), .resp(resp),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5;
            cyc = cyc + 1;    // counted just before the rising edge
            clk = 1'b1;
            #5;
            clk = 1'b0;
        end
    end

    task automatic abortRun(string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic reportMismatch(string sig, logic [31:0] got, logic [31:0] exp);
        abortRun($sformatf("** Error %s: got 0x%h, expected 0x%h", sig, got, exp));
    endtask

    task automatic checkResp(csrRespT got, csrRespT exp);
        if (got.valid !== exp.valid) reportMismatch("resp.valid", got.valid, exp.valid);
        if (got.hartId !== exp.hartId) reportMismatch("resp.hartId", got.hartId, exp.hartId);
        if (got.rdata !== exp.rdata) reportMismatch("resp.rdata", got.rdata, exp.rdata);
        if (got.redirect !== exp.redirect) begin
            reportMismatch("resp.redirect", got.redirect, exp.redirect);
        end
        if (got.target !== exp.target) reportMismatch("resp.target", got.target, exp.target);
        if (got.irqPending !== exp.irqPending) begin
            reportMismatch("resp.irqPending", got.irqPending, exp.irqPending);
        end
    endtask

    task automatic checkApb(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) reportMismatch({"prdata (", name, ")"}, got, exp);
    endtask

    function automatic int randBelow(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic csrCmdT makeCmd(int h, cmdKindT k, csrOpT op, csrNumT n,
                                       logic [31:0] wdata);
        csrCmdT c;
        c         = '0;
        c.valid   = 1'b1;
        c.hartId  = 8'(h);
        c.kind    = k;
        c.op      = op;
        c.num     = n;
        c.wdata   = wdata;
        c.cause   = legalCauses[randBelow(8)];
        c.pc      = $random(seed) & 32'hFFFF_FFFC;
        c.tval    = $random(seed);
        c.retired = 2'(randBelow(4));
        return c;
    endfunction

    task automatic sendCmd(csrCmdT c);
        expT e;
        @(posedge clk);
        e     = predict(c);
        e.due = 32'(cyc + 2);
        if (e.resp.valid) expQ.push_back(e);
        cmd <= c;
    endtask

    task automatic releaseCmd();
        @(posedge clk);
        cmd <= '0;
    endtask

    task automatic drain();
        while (expQ.size() != 0) @(posedge clk);
    endtask

    task automatic apbAccess(logic wr, logic [11:0] addr, logic [31:0] wdata,
                             output logic [31:0] rdata, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);    // access phase, outputs settled
        rdata = prdata;
        err   = pslverr;
        if (pready !== 1'b1) abortRun("APB pready was low in the access phase");
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apbWrite(logic [11:0] addr, logic [31:0] data);
        logic [31:0] rd;
        logic        err;
        apbAccess(1'b1, addr, data, rd, err);
        if (err) abortRun($sformatf("APB write to 0x%h was rejected with pslverr", addr));
    endtask

    // Response checker expects each response two cycles after its command
    always @(negedge clk) begin
        expT e;
        if (rstN) begin
            if (resp.valid) begin
                if (expQ.size() == 0) begin
                    abortRun("A response came out with no command outstanding");
                end else begin
                    e = expQ.pop_front();
                    if (e.due != 32'(cyc)) abortRun("A response came out at the wrong cycle");
                    if (e.boundOnly) begin
                        if (resp.rdata < e.bound) begin
                            abortRun($sformatf("** Error resp.rdata (mcycle): got 0x%h, %s 0x%h",
                                resp.rdata, "expected at least", e.bound));
                        end
                        e.resp.rdata = resp.rdata;
                    end
                    checkResp(resp, e.resp);
                    if (e.trackCycle) cycleBound[e.resp.hartId] = resp.rdata + 32'd1;
                end
            end else if (expQ.size() != 0 && expQ[0].due <= 32'(cyc)) begin
                abortRun("An expected response did not arrive two cycles after its command");
            end
        end
        if (cyc > LimitCycles) abortRun("Timeout, the run took longer than its cycle budget");
    end

    initial begin
        int          h;
        int          other;
        logic [31:0] rd;
        logic [31:0] lastTime;
        logic        err;
        rstN    = 1'b0;
        cmd     = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        for (int i = 0; i < NumHarts; i++) begin
            modelCsr[i]   = '0;
            cycleBound[i] = '0;
            modelMtip[i]  = 1'b0;
        end
        repeat (ResetCycles) @(posedge clk);
        rstN <= 1'b1;

        // Random CSR operations back to back or with gaps
        for (int i = 0; i < NumRandOps; i++) begin
            sendCmd(makeCmd(randBelow(NumHarts), CSR_OP, csrOpT'(2'(randBelow(4))),
                rwNums[randBelow(5)], $random(seed)));
            if (randBelow(2) == 0) releaseCmd();
        end
        sendCmd(makeCmd(NumHarts + 2, CSR_OP, READ, CSR_MSCRATCH, '0));    // dropped
        releaseCmd();
        drain();

        // Trap followed by state readback and MRET
        for (int i = 0; i < NumTraps; i++) begin
            h = randBelow(NumHarts);
            sendCmd(makeCmd(h, CSR_OP, (randBelow(2) == 0) ? SET : CLEAR, CSR_MSTATUS, 32'h8));
            sendCmd(makeCmd(h, TRAP, READ, CSR_MSTATUS, '0));
            sendCmd(makeCmd(h, CSR_OP, READ, CSR_MEPC, '0));
            sendCmd(makeCmd(h, CSR_OP, READ, CSR_MCAUSE, '0));
            sendCmd(makeCmd(h, CSR_OP, READ, CSR_MTVAL, '0));
            sendCmd(makeCmd(h, CSR_OP, READ, CSR_MSTATUS, '0));
            sendCmd(makeCmd(h, MRET, READ, CSR_MSTATUS, '0));
            releaseCmd();
            drain();
        end

        // Timer interrupt entry in direct and vectored mode
        for (int i = 0; i < NumIrqs; i++) begin
            h = randBelow(NumHarts);
            sendCmd(makeCmd(h, CSR_OP, WRITE, CSR_MTVEC,
                ($random(seed) & 32'hFFFF_FFFC) | 32'(i % 2)));
            sendCmd(makeCmd(h, INTERRUPT, READ, CSR_MSTATUS, '0));
            sendCmd(makeCmd(h, CSR_OP, READ, CSR_MCAUSE, '0));
            sendCmd(makeCmd(h, MRET, READ, CSR_MSTATUS, '0));
            releaseCmd();
            drain();
        end

        // Timer over APB
        h     = 1;
        other = 2;
        sendCmd(makeCmd(h, CSR_OP, SET, CSR_MSTATUS, 32'h8));
        sendCmd(makeCmd(h, CSR_OP, SET, CSR_MIE, 32'h80));
        releaseCmd();
        drain();
        apbWrite(12'(16 + 8 * h), 32'h0);
        apbWrite(12'(20 + 8 * h), 32'h0);
        apbAccess(1'b0, 12'(16 + 8 * h), '0, rd, err);
        checkApb("mtimecmp low", rd, 32'h0);
        repeat (4) @(posedge clk);    // through the irq register and into mip
        modelMtip[h] = 1'b1;
        sendCmd(makeCmd(h, CSR_OP, READ, CSR_MIP, '0));
        sendCmd(makeCmd(h, CSR_OP, READ, CSR_MIP, '0));
        sendCmd(makeCmd(other, CSR_OP, READ, CSR_MIP, '0));
        releaseCmd();
        drain();
        apbWrite(12'(20 + 8 * h), 32'hFFFF_FFFF);
        apbWrite(12'(16 + 8 * h), 32'hFFFF_FFFF);
        apbAccess(1'b0, 12'(20 + 8 * h), '0, rd, err);
        checkApb("mtimecmp high", rd, 32'hFFFF_FFFF);
        repeat (4) @(posedge clk);
        modelMtip[h] = 1'b0;
        sendCmd(makeCmd(h, CSR_OP, READ, CSR_MIP, '0));
        releaseCmd();
        drain();
        lastTime = '0;
        for (int i = 0; i < NumTimeRds; i++) begin
            repeat (10) @(posedge clk);    // several TickDiv periods between reads
            apbAccess(1'b0, 12'h000, '0, rd, err);
            if (rd <= lastTime) begin
                abortRun($sformatf("** Error prdata (mtime): got 0x%h after 0x%h, no tick seen",
                    rd, lastTime));
            end
            lastTime = rd;
        end
        apbAccess(1'b0, 12'h004, '0, rd, err);
        checkApb("mtime high", rd, 32'h0);
        apbAccess(1'b0, 12'h008, '0, rd, err);
        if (err !== 1'b1) reportMismatch("pslverr", err, 32'h1);
        apbAccess(1'b0, 12'(16 + 8 * NumHarts), '0, rd, err);
        if (err !== 1'b1) reportMismatch("pslverr", err, 32'h1);
        apbAccess(1'b0, 12'h000, '0, rd, err);
        if (err !== 1'b0) reportMismatch("pslverr", err, 32'h0);

        // Counters
        h = 2;
        for (int i = 0; i < NumRetire; i++) begin
            sendCmd(makeCmd(h, CSR_OP, READ, CSR_MSCRATCH, '0));
        end
        sendCmd(makeCmd(h, CSR_OP, READ, CSR_MINSTRET, '0));
        releaseCmd();
        drain();
        for (int i = 0; i < 4; i++) begin
            if (i == 2) begin
                sendCmd(makeCmd(h, CSR_OP, WRITE, CSR_MCYCLE, 32'h0100_0000));
            end else begin
                sendCmd(makeCmd(h, CSR_OP, READ, CSR_MCYCLE, '0));
            end
            releaseCmd();
            drain();
        end
        sendCmd(makeCmd(h, CSR_OP, WRITE, CSR_MINSTRET, 32'h0000_0100));
        sendCmd(makeCmd(h, CSR_OP, READ, CSR_MINSTRET, '0));
        releaseCmd();
        drain();

        repeat (4) @(posedge clk);
        if (expQ.size() != 0) begin
            abortRun("Responses were still outstanding at the end of the run");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

//--- vlog.f
+incdir+test
logic/csrPkg.sv
logic/clusterPkg.sv
logic/csrCmdRouter.sv
logic/csrUnit.sv
logic/csrRespCollector.sv
logic/clintTimer.sv
logic/csrCluster.sv
test/csrClusterTb.sv
